/* hw/led_defs.svh */
// Widths, register map and bit positions for the string LED streamer
// Included by the package and by any module sizing buses or decoding registers
`ifndef LED_DEFS_SVH
`define LED_DEFS_SVH

`default_nettype none

`define LED_ADDR_W        8   // Buffer address for 256 bytes
`define LED_COUNT_W       4   // Window repeat count
`define LED_WB_W          32  // Bus address and data
`define LED_MEM_SEL_BIT   12  // Address bit that selects the buffer region

// Register word offsets from adr[3:2]
`define LED_REG_CONFIG    2'd0
`define LED_REG_CTRL      2'd1
`define LED_REG_FIRST     2'd2
`define LED_REG_LAST      2'd3

`define LED_CFG_EN_BIT     31  // CONFIG streamer enable
`define LED_CFG_IRQ_BIT    30  // CONFIG interrupt enable
`define LED_CTRL_START_BIT 31  // Write-only CTRL start
`define LED_CTRL_BUSY_BIT  30  // Read-only CTRL busy

`default_nettype wire

`endif

/* hw/led_pkg.sv */
// Types shared across the LED streamer
// Bus request/response, sequencer window, buffer write and the two enums
`include "led_defs.svh"
`default_nettype none

package led_pkg;

  // Bus request from the master
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`LED_WB_W-1:0]   adr;
    logic [`LED_WB_W-1:0]   dat;
    logic [`LED_WB_W/8-1:0] sel;   // Byte enables
  } wb_req_t;

  typedef struct packed {
    logic [`LED_WB_W-1:0] dat;     // Valid with ack
    logic                 ack;     // One cycle
  } wb_rsp_t;

  // Frame window as programmed
  typedef struct packed {
    logic [`LED_ADDR_W-1:0]  first;
    logic [`LED_ADDR_W-1:0]  last;
    logic [`LED_COUNT_W-1:0] count;  // Extra passes
  } seq_cfg_t;

  typedef struct packed {
    logic                   en;
    logic [`LED_ADDR_W-1:0] addr;
    logic [7:0]             data;
  } mem_wr_t;

  typedef enum logic [1:0] {
    S_IDLE,    // Waiting for start
    S_FETCH,   // Read strobe to buffer
    S_WAIT,    // Read data lands
    S_HAND     // Hold byte until serializer empty
  } seq_state_e;

  typedef enum logic [1:0] {
    REG_CONFIG = `LED_REG_CONFIG,
    REG_CTRL   = `LED_REG_CTRL,
    REG_FIRST  = `LED_REG_FIRST,
    REG_LAST   = `LED_REG_LAST
  } reg_sel_e;

endpackage

`default_nettype wire

/* hw/led_pixel_buffer.sv */
// Byte buffer holding the LED frame data
// One write port from the bus side, one synchronous read port for the sequencer
`timescale 1ns/1ps
`include "led_defs.svh"
`default_nettype none

module led_pixel_buffer (
  input  wire                      clk,
  input  wire led_pkg::mem_wr_t    wr_i,       // Bus side write
  input  wire                      rd_en_i,
  input  wire  [`LED_ADDR_W-1:0]   rd_addr_i,
  output logic [7:0]               rd_data_o   // Valid one cycle after rd_en
);

  localparam int DEPTH = 1 << `LED_ADDR_W;

  logic [7:0] mem_q [0:DEPTH-1];  // Inferred array

  always_ff @(posedge clk) begin
    if (wr_i.en) begin
      mem_q[wr_i.addr] <= wr_i.data;
    end
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];  // Holds between reads
    end
  end

endmodule

`default_nettype wire

/* hw/led_bit_serializer.sv */
// Bit serializer for the LED streamer
// Takes one byte, presents it MSB first under a valid/ready pair
`timescale 1ns/1ps
`default_nettype none

module led_bit_serializer (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        clear_i,      // Drop held bits
  input  wire        load_i,       // Only raised while empty
  input  wire  [7:0] byte_i,
  output logic       empty_o,
  output logic       bit_o,
  output logic       bit_valid_o,
  input  wire        bit_ready_i
);

  logic [7:0] shift_q;   // MSB is the bit on offer
  logic [3:0] left_q;    // Bits still to send
  logic       take;

  assign empty_o     = (left_q == 4'd0);
  assign bit_valid_o = ~empty_o;
  assign bit_o       = shift_q[7];
  assign take        = bit_valid_o & bit_ready_i;  // One bit consumed

  always_ff @(posedge clk) begin
    if (!rst_n || clear_i) begin
      left_q <= 4'd0;
    end else if (load_i) begin
      left_q <= 4'd8;
    end else if (take) begin
      left_q <= left_q - 4'd1;
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (load_i) begin
      shift_q <= byte_i;
    end else if (take) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* hw/led_frame_sequencer.sv */
// Frame sequencer for the LED streamer
// Walks the buffer window first..last, count+1 times, and hands bytes to the
// serializer one at a time
`timescale 1ns/1ps
`include "led_defs.svh"
`default_nettype none

module led_frame_sequencer (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      enable_i,   // Low forces IDLE
  input  wire                      start_i,
  input  wire led_pkg::seq_cfg_t   cfg_i,
  output logic                     busy_o,
  output logic                     rd_en_o,
  output logic [`LED_ADDR_W-1:0]   rd_addr_o,
  input  wire  [7:0]               rd_data_i,
  input  wire                      empty_i,    // Serializer can take a byte
  output logic                     load_o,
  output logic [7:0]               byte_o
);
  import led_pkg::*;

  seq_state_e              state_q;
  logic [`LED_ADDR_W-1:0]  addr_q;     // Current word
  logic [`LED_ADDR_W-1:0]  first_q;
  logic [`LED_ADDR_W-1:0]  last_q;
  logic [`LED_COUNT_W-1:0] count_q;    // Passes left after this one
  logic                    start_go;
  logic                    hand_go;    // Byte accepted by serializer
  logic                    at_last;

  assign start_go  = (state_q == S_IDLE) & start_i & enable_i;
  assign hand_go   = (state_q == S_HAND) & empty_i;
  assign at_last   = (addr_q == last_q);
  assign rd_en_o   = (state_q == S_FETCH);
  assign rd_addr_o = addr_q;
  assign load_o    = hand_go;
  assign byte_o    = rd_data_i;                       // Buffer holds last read
  assign busy_o    = (state_q != S_IDLE) | ~empty_i;  // Includes bits in flight

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (start_go) state_q <= S_FETCH;
        S_FETCH: state_q <= S_WAIT;
        S_WAIT:  state_q <= S_HAND;
        default: begin
          if (hand_go) begin
            // Last word of last pass ends the frame
            state_q <= (at_last && count_q == '0) ? S_IDLE : S_FETCH;
          end
        end
      endcase
    end
  end

  // Window and address walk
  always_ff @(posedge clk) begin
    if (start_go) begin
      first_q <= cfg_i.first;
      last_q  <= cfg_i.last;
      addr_q  <= cfg_i.first;
      count_q <= cfg_i.count;
    end else if (hand_go) begin
      if (!at_last) begin
        addr_q <= addr_q + 1'b1;
      end else begin
        addr_q  <= first_q;          // Wrap for next pass
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/led_bus_decode.sv */
// Wishbone register slave for the LED streamer
// Holds CONFIG and window registers, writes the byte buffer, raises start and irq
`timescale 1ns/1ps
`include "led_defs.svh"
`default_nettype none

module led_bus_decode (
  input  wire                clk,
  input  wire                rst_n,
  input  wire led_pkg::wb_req_t wb_req_i,
  output led_pkg::wb_rsp_t   wb_rsp_o,
  output led_pkg::seq_cfg_t  cfg_o,     // Window to sequencer
  output logic               enable_o,  // CONFIG enable
  output logic               start_o,   // One-cycle start pulse
  output led_pkg::mem_wr_t   mem_wr_o,  // One-cycle buffer write
  input  wire                busy_i,
  output logic               irq_o
);
  import led_pkg::*;

  logic                 req_go;    // New request not yet acked
  logic                 mem_hit;   // Buffer region
  logic                 reg_wr;
  reg_sel_e             reg_sel;
  logic [`LED_WB_W-1:0] rd_word;
  logic                 irq_en_q;
  logic                 busy_q;    // Busy delayed for edge detect

  assign req_go  = wb_req_i.cyc & wb_req_i.stb & ~wb_rsp_o.ack;
  assign mem_hit = wb_req_i.adr[`LED_MEM_SEL_BIT];
  assign reg_wr  = req_go & ~mem_hit & wb_req_i.we;
  assign reg_sel = reg_sel_e'(wb_req_i.adr[3:2]);

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_word = '0;
    case (reg_sel)
      REG_CONFIG: begin
        rd_word[`LED_CFG_EN_BIT]  = enable_o;
        rd_word[`LED_CFG_IRQ_BIT] = irq_en_q;
      end
      REG_CTRL: begin
        rd_word[`LED_CTRL_BUSY_BIT] = busy_i;  // Live status
        rd_word[`LED_COUNT_W-1:0]   = cfg_o.count;
      end
      REG_FIRST: rd_word[`LED_ADDR_W-1:0] = cfg_o.first;
      default:   rd_word[`LED_ADDR_W-1:0] = cfg_o.last;
    endcase
    if (mem_hit) begin
      rd_word = '0;  // Buffer is write only
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers, strobes and interrupt
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_rsp_o.ack <= 1'b0;
      start_o      <= 1'b0;
      mem_wr_o.en  <= 1'b0;
      enable_o     <= 1'b0;
      irq_en_q     <= 1'b0;
      cfg_o        <= '0;
      busy_q       <= 1'b0;
      irq_o        <= 1'b0;
    end else begin
      wb_rsp_o.ack <= req_go;                       // Ack one cycle later
      mem_wr_o.en  <= req_go & mem_hit & wb_req_i.we;
      start_o      <= reg_wr & (reg_sel == REG_CTRL) & wb_req_i.sel[3]
                      & wb_req_i.dat[`LED_CTRL_START_BIT];
      busy_q       <= busy_i;
      irq_o        <= irq_en_q & busy_q & ~busy_i;  // Falling edge of busy
      if (reg_wr) begin
        case (reg_sel)
          REG_CONFIG: if (wb_req_i.sel[3]) begin
            enable_o <= wb_req_i.dat[`LED_CFG_EN_BIT];
            irq_en_q <= wb_req_i.dat[`LED_CFG_IRQ_BIT];
          end
          REG_CTRL:  if (wb_req_i.sel[0]) cfg_o.count <= wb_req_i.dat[`LED_COUNT_W-1:0];
          REG_FIRST: if (wb_req_i.sel[0]) cfg_o.first <= wb_req_i.dat[`LED_ADDR_W-1:0];
          default:   if (wb_req_i.sel[0]) cfg_o.last  <= wb_req_i.dat[`LED_ADDR_W-1:0];
        endcase
      end
    end
    // Payload qualified by ack and en
    if (req_go) begin
      wb_rsp_o.dat <= rd_word;
    end
    mem_wr_o.addr <= wb_req_i.adr[`LED_ADDR_W+1:2];  // Word address
    mem_wr_o.data <= wb_req_i.dat[7:0];
  end

endmodule

`default_nettype wire

/* hw/string_led_top.sv */
// Top level of the string LED frame streamer
// Bus slave, byte buffer, frame sequencer and bit serializer wired together
`timescale 1ns/1ps
`include "led_defs.svh"
`default_nettype none

module string_led_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire led_pkg::wb_req_t   wb_req_i,
  output led_pkg::wb_rsp_t        wb_rsp_o,
  output wire                     bit_o,
  output wire                     bit_valid_o,
  input  wire                     bit_ready_i,
  output wire                     irq_o
);
  import led_pkg::*;

  seq_cfg_t               cfg;
  mem_wr_t                mem_wr;
  logic                   enable;
  logic                   start;
  logic                   busy;
  logic                   rd_en;
  logic [`LED_ADDR_W-1:0] rd_addr;
  logic [7:0]             rd_data;
  logic                   empty;
  logic                   load;
  logic [7:0]             load_byte;

  led_bus_decode u_decode (
    .clk(clk), .rst_n(rst_n), .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o),
    .cfg_o(cfg), .enable_o(enable), .start_o(start), .mem_wr_o(mem_wr),
    .busy_i(busy), .irq_o(irq_o)
  );

  led_pixel_buffer u_buffer (
    .clk(clk), .wr_i(mem_wr), .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_data_o(rd_data)
  );

  led_frame_sequencer u_execute (
    .clk(clk), .rst_n(rst_n), .enable_i(enable), .start_i(start), .cfg_i(cfg),
    .busy_o(busy), .rd_en_o(rd_en), .rd_addr_o(rd_addr), .rd_data_i(rd_data),
    .empty_i(empty), .load_o(load), .byte_o(load_byte)
  );

  // Disable empties the serializer
  led_bit_serializer u_result (
    .clk(clk), .rst_n(rst_n), .clear_i(~enable), .load_i(load), .byte_i(load_byte),
    .empty_o(empty), .bit_o(bit_o), .bit_valid_o(bit_valid_o), .bit_ready_i(bit_ready_i)
  );

endmodule

`default_nettype wire

/* bench/tb_bus_tasks.svh */
// Bus master tasks for the LED streamer testbench
// Included inside the testbench module to drive wb_req and check ack timing
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// One request held until ack with every change on a falling edge
task automatic bus_cycle(input logic write, input logic [31:0] adr,
                         input logic [31:0] wdat, input logic [3:0] sel,
                         output logic [31:0] rdat);
  int waited;
  waited = 0;
  @(negedge clk);
  wb_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: wdat, sel: sel};
  do begin
    @(negedge clk);
    waited++;
  end while (!wb_rsp.ack && waited < 16);  // Give up on a dead slave
  expect_true(wb_rsp.ack && waited == 1,
              $sformatf("bus request to %h was not acked in the next cycle", adr));
  rdat   = wb_rsp.dat;
  wb_req = '0;                             // Drop request in the ack cycle
  @(negedge clk);
  expect_true(!wb_rsp.ack, $sformatf("ack to %h stayed high past one cycle", adr));
endtask

task automatic bus_write(input logic [31:0] adr, input logic [31:0] wdat,
                         input logic [3:0] sel);
  logic [31:0] ignored;
  bus_cycle(1'b1, adr, wdat, sel, ignored);
endtask

task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
  bus_cycle(1'b0, adr, 32'd0, 4'hF, rdat);
endtask

`endif

/* bench/tb_string_led.sv */
// Testbench for the string LED frame streamer
// Register readback, table-driven frames against a predicted bit stream,
// interrupt pulses and a mid-frame disable
`timescale 1ns/1ps
`include "led_defs.svh"
`default_nettype none

module tb_string_led;
  import led_pkg::*;

  typedef struct packed {
    logic [7:0] first;
    logic [7:0] last;
    logic [3:0] count;       // Extra passes
    logic       irq_en;
    logic       rand_ready;  // Random back-pressure
    logic [7:0] pattern;     // Buffer fill seed
  } row_t;

  typedef struct packed {
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] wdat;
    logic [31:0] exp;        // Readback after the write
  } reg_row_t;

  localparam logic [31:0] ADR_CONFIG = {28'd0, `LED_REG_CONFIG, 2'b00};
  localparam logic [31:0] ADR_CTRL   = {28'd0, `LED_REG_CTRL, 2'b00};
  localparam logic [31:0] ADR_FIRST  = {28'd0, `LED_REG_FIRST, 2'b00};
  localparam logic [31:0] ADR_LAST   = {28'd0, `LED_REG_LAST, 2'b00};
  localparam logic [31:0] MEM_BASE   = 32'd1 << `LED_MEM_SEL_BIT;
  localparam int NROWS = 6;
  localparam int ROW_BITS_MAX = 16 * 4 * 8;  // Widest window x passes x bits
  localparam int WATCHDOG_CYCLES = (NROWS + 2) * ROW_BITS_MAX * 4 + 4000;

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        bit_o, bit_valid_o, bit_ready_i, irq_o;
  int          errors = 0;
  int          checks = 0;

  row_t rows [NROWS] = '{
    '{8'd0,   8'd3,   4'd0, 1'b1, 1'b0, 8'hA5},
    '{8'd10,  8'd10,  4'd0, 1'b0, 1'b0, 8'h3C},  // Single word
    '{8'd20,  8'd22,  4'd2, 1'b1, 1'b1, 8'h5A},
    '{8'd255, 8'd255, 4'd1, 1'b1, 1'b1, 8'h0F},  // Top word repeated
    '{8'd100, 8'd111, 4'd0, 1'b0, 1'b1, 8'hC3},
    '{8'd40,  8'd47,  4'd3, 1'b1, 1'b1, 8'h96}
  };

  reg_row_t regs [9] = '{
    '{ADR_CONFIG, 4'b1000, 32'hC000_0000, 32'hC000_0000},
    '{ADR_CONFIG, 4'b0111, 32'h0000_0000, 32'hC000_0000},  // Top byte off
    '{ADR_CONFIG, 4'b1000, 32'h4000_0000, 32'h4000_0000},  // Irq only
    '{ADR_FIRST,  4'b0001, 32'h1234_5678, 32'h0000_0078},
    '{ADR_FIRST,  4'b1110, 32'h0000_00FF, 32'h0000_0078},
    '{ADR_LAST,   4'b0001, 32'hFFFF_FF9A, 32'h0000_009A},
    '{ADR_CTRL,   4'b0001, 32'h0000_0005, 32'h0000_0005},
    '{ADR_CTRL,   4'b1110, 32'h7FFF_FFFA, 32'h0000_0005},  // Neither start nor count
    '{MEM_BASE | 32'd4, 4'b0001, 32'h0000_0011, 32'h0000_0000}
  };

  string_led_top dut_i (
    .clk(clk), .rst_n(rst_n), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp), .bit_o(bit_o),
    .bit_valid_o(bit_valid_o), .bit_ready_i(bit_ready_i), .irq_o(irq_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reference model
  ////////////////////////////////////////////////////////////////////////////
  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", msg);
    end
  endtask

  // Odd multiplier so every address bit shows in the byte
  function automatic logic [7:0] fill_byte(input logic [7:0] pattern, input logic [7:0] addr);
    return pattern ^ (addr * 8'd37);
  endfunction

  function automatic logic draw_ready();
    return ($urandom % 32'd3) != 32'd0;  // Ready about two cycles in three
  endfunction

  `include "tb_bus_tasks.svh"

  ////////////////////////////////////////////////////////////////////////////
  // One frame from a table row
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_row(input row_t r, input int idx);
    logic        exp_q[$];
    logic        got_q[$];
    logic [7:0]  b;
    logic [31:0] rd;
    int          w, p, k, cyc, irq_during, irq_after, err0;
    for (w = int'(r.first); w <= int'(r.last); w++) begin
      bus_write(MEM_BASE | (w << 2), {24'd0, fill_byte(r.pattern, w[7:0])}, 4'h1);
    end
    bus_write(ADR_CONFIG, {1'b1, r.irq_en, 30'd0}, 4'b1000);
    bus_write(ADR_FIRST, {24'd0, r.first}, 4'b0001);
    bus_write(ADR_LAST, {24'd0, r.last}, 4'b0001);
    // Window in order, MSB first, count+1 passes
    for (p = 0; p <= int'(r.count); p++) begin
      for (w = int'(r.first); w <= int'(r.last); w++) begin
        b = fill_byte(r.pattern, w[7:0]);
        for (k = 7; k >= 0; k--) begin
          exp_q.push_back(b[k]);
        end
      end
    end
    bus_write(ADR_CTRL, {1'b1, 27'd0, r.count}, 4'b1001);  // Count and start
    cyc = 0;
    irq_during = 0;
    irq_after = 0;
    while (got_q.size() < exp_q.size() && cyc < exp_q.size() * 8 + 100) begin
      @(negedge clk);
      cyc++;
      bit_ready_i = r.rand_ready ? draw_ready() : 1'b1;
      if (irq_o) irq_during++;
      if (bit_valid_o && bit_ready_i) got_q.push_back(bit_o);  // Taken next edge
    end
    bit_ready_i = 1'b1;
    repeat (8) begin                                  // Tail catches extra bits
      @(negedge clk);
      if (irq_o) irq_after++;
      if (bit_valid_o) got_q.push_back(bit_o);
    end
    compare_word($sformatf("bit_o count row %0d", idx), got_q.size(), exp_q.size());
    err0 = errors;
    for (k = 0; k < exp_q.size() && k < got_q.size() && errors == err0; k++) begin
      compare_word($sformatf("bit_o row %0d bit %0d", idx, k), {31'd0, got_q[k]},
                   {31'd0, exp_q[k]});
    end
    compare_word($sformatf("irq_o in frame row %0d", idx), irq_during, 32'd0);
    compare_word($sformatf("irq_o width row %0d", idx), irq_after, {31'd0, r.irq_en});
    bus_read(ADR_CTRL, rd);
    compare_word($sformatf("CTRL row %0d", idx), rd, {28'd0, r.count});  // Busy clear
  endtask

  task automatic disable_mid_frame();
    logic [31:0] rd;
    int          cyc, seen;
    bus_write(ADR_CONFIG, 32'h8000_0000, 4'b1000);   // Enable with irq off
    bus_write(ADR_FIRST, 32'd0, 4'b0001);
    bus_write(ADR_LAST, 32'd15, 4'b0001);
    bus_write(ADR_CTRL, 32'h8000_0003, 4'b1001);
    cyc = 0;
    while (!bit_valid_o && cyc < 50) begin
      @(negedge clk);
      cyc++;
    end
    expect_true(bit_valid_o, "frame never started before the disable");
    repeat (20) @(negedge clk);                      // Well inside the frame
    bus_write(ADR_CONFIG, 32'd0, 4'b1000);
    seen = 0;
    repeat (40) begin
      @(negedge clk);
      if (bit_valid_o) seen++;
    end
    compare_word("bit_valid_o cycles after disable", seen, 32'd0);
    bus_read(ADR_CTRL, rd);
    compare_word("CTRL after disable", rd, 32'h0000_0003);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    int          i;
    void'($urandom(84));
    rst_n       = 1'b0;
    wb_req      = '0;
    bit_ready_i = 1'b1;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compare_word("bit_valid_o after reset", {31'd0, bit_valid_o}, 32'd0);
    compare_word("irq_o after reset", {31'd0, irq_o}, 32'd0);
    compare_word("wb_rsp_o.ack after reset", {31'd0, wb_rsp.ack}, 32'd0);
    for (i = 0; i < 9; i++) begin
      bus_write(regs[i].adr, regs[i].wdat, regs[i].sel);
      bus_read(regs[i].adr, rd);
      compare_word($sformatf("wb_rsp_o.dat reg row %0d", i), rd, regs[i].exp);
    end
    for (i = 0; i < NROWS; i++) begin
      run_row(rows[i], i);
    end
    disable_mid_frame();
    run_row(rows[0], NROWS);                         // Recovers after disable
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("summary: %0d checks, %0d errors", checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
+incdir+bench
hw/led_pkg.sv
hw/led_pixel_buffer.sv
hw/led_bit_serializer.sv
hw/led_frame_sequencer.sv
hw/led_bus_decode.sv
hw/string_led_top.sv
bench/tb_string_led.sv

/* Makefile */
# Verilator build and run for the string LED frame streamer
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_string_led
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
